//--- mopshub_pkg.sv
package mopshub_pkg;

  // Hub dimensions
  localparam int n_buses  = 8;
  localparam int bus_id_w = 8;
  localparam int frame_w  = 76;

  // 2-bit symbols per frame on the e-link
  localparam int sym_per_frame = 38;

  // cob_id plus data, as sent on a field bus
  localparam int msg_bits = 68;

  localparam int chan_fifo_depth = 2;
  localparam int up_fifo_depth   = 4;

  // E-link symbols
  localparam logic [1:0] elink_idle  = 2'b00;
  localparam logic [1:0] elink_start = 2'b11;

  // APB register map
  localparam logic [3:0] addr_bus_en     = 4'h0;
  localparam logic [3:0] addr_tx_count   = 4'h4;
  localparam logic [3:0] addr_rx_count   = 4'h8;
  localparam logic [3:0] addr_drop_count = 4'hC;

  localparam logic [n_buses-1:0] bus_en_reset = '1;

  typedef struct packed {
    logic [11:0] cob_id;
    logic [55:0] data;
  } can_msg_t;

  // Bus number goes out first on the e-link
  typedef struct packed {
    logic [bus_id_w-1:0] bus_id;
    can_msg_t            msg;
  } hub_frame_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  depth  = 2
) (
  input  logic  clk_40,
  input  logic  rst,
  input  logic  push,
  input  item_t push_item,
  output logic  full,
  input  logic  pop,
  output item_t pop_item,
  output logic  empty
);

  item_t                      mem [depth];
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth+1)-1:0] count;
  logic                       do_push;
  logic                       do_pop;

  assign full    = count == ($clog2(depth+1))'(depth);
  assign empty   = count == '0;
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head of queue is visible without a pop
  assign pop_item = mem[rd_ptr];

  always_ff @(posedge clk_40)
  begin
    if (do_push)
      mem[wr_ptr] <= push_item;
  end

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == ($clog2(depth))'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ($clog2(depth))'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- elink_deser.sv
`timescale 1ns/1ps

module elink_deser
  import mopshub_pkg::*;
(
  input  logic       clk_40,
  input  logic       rst,
  input  logic [1:0] elink_rx,
  output logic       dn_valid,
  output hub_frame_t dn_frame
);

  typedef enum logic {
    st_idle,
    st_collect
  } state_t;

  state_t             state;
  logic [5:0]         sym_cnt;
  logic [frame_w-1:0] shreg;

  assign dn_frame = hub_frame_t'(shreg);

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      state    <= st_idle;
      sym_cnt  <= '0;
      dn_valid <= 1'b0;
    end
    else
    begin
      dn_valid <= 1'b0;
      case (state)
        st_idle:
        begin
          // Start symbol only counts between frames
          if (elink_rx == elink_start)
          begin
            state   <= st_collect;
            sym_cnt <= '0;
          end
        end
        st_collect:
        begin
          sym_cnt <= sym_cnt + 1'b1;
          if (sym_cnt == 6'(sym_per_frame - 1))
          begin
            state    <= st_idle;
            dn_valid <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // MSB symbol arrives first
  always_ff @(posedge clk_40)
  begin
    if (state == st_collect)
      shreg <= {shreg[frame_w-3:0], elink_rx};
  end

endmodule

//--- elink_ser.sv
`timescale 1ns/1ps

module elink_ser
  import mopshub_pkg::*;
(
  input  logic       clk_40,
  input  logic       rst,
  input  logic       up_valid,
  input  hub_frame_t up_frame,
  output logic       up_ready,
  output logic [1:0] elink_tx,
  output logic       up_pulse
);

  logic               busy;
  logic [5:0]         sym_cnt;
  logic [frame_w-1:0] shreg;

  assign up_ready = !busy;
  assign up_pulse = up_valid && up_ready;

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      busy     <= 1'b0;
      sym_cnt  <= '0;
      elink_tx <= elink_idle;
    end
    else if (!busy)
    begin
      if (up_valid)
      begin
        busy     <= 1'b1;
        sym_cnt  <= '0;
        elink_tx <= elink_start;
      end
      else
        elink_tx <= elink_idle;
    end
    else
    begin
      elink_tx <= shreg[frame_w-1 -: 2];
      sym_cnt  <= sym_cnt + 1'b1;
      // Next frame may start right after the last symbol
      if (sym_cnt == 6'(sym_per_frame - 1))
        busy <= 1'b0;
    end
  end

  always_ff @(posedge clk_40)
  begin
    if (up_pulse)
      shreg <= up_frame;
    else if (busy)
      shreg <= {shreg[frame_w-3:0], 2'b00};
  end

endmodule

//--- bus_channel.sv
`timescale 1ns/1ps

module bus_channel
  import mopshub_pkg::*;
(
  input  logic     clk_40,
  input  logic     rst,
  input  logic     tx_push,
  input  can_msg_t tx_msg,
  output logic     tx_full,
  output logic     bus_tx,
  input  logic     bus_rx,
  output logic     rx_valid,
  output can_msg_t rx_msg,
  input  logic     rx_grant,
  output logic     overrun
);

  can_msg_t              tx_head;
  logic                  tx_empty;
  logic                  tx_pop;
  logic                  tx_busy;
  logic [6:0]            tx_cnt;
  logic [msg_bits:0]     tx_sh;
  logic                  rx_busy;
  logic                  rx_prev;
  logic [6:0]            rx_cnt;
  logic [msg_bits-1:0]   rx_sh;
  logic                  rx_done;

  sync_fifo #(
    .item_t (can_msg_t),
    .depth  (chan_fifo_depth)
  ) i_tx_fifo (
    .clk_40    (clk_40),
    .rst       (rst),
    .push      (tx_push),
    .push_item (tx_msg),
    .full      (tx_full),
    .pop       (tx_pop),
    .pop_item  (tx_head),
    .empty     (tx_empty)
  );

  assign tx_pop = !tx_busy && !tx_empty;

  // Start bit, 68 bits LSB first, stop bit
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      tx_busy <= 1'b0;
      tx_cnt  <= '0;
      bus_tx  <= 1'b1;
    end
    else if (!tx_busy)
    begin
      bus_tx <= !tx_pop;
      if (tx_pop)
      begin
        tx_busy <= 1'b1;
        tx_cnt  <= '0;
      end
    end
    else
    begin
      bus_tx <= tx_sh[0];
      tx_cnt <= tx_cnt + 1'b1;
      if (tx_cnt == 7'(msg_bits))
        tx_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk_40)
  begin
    if (tx_pop)
      tx_sh <= {1'b1, tx_head};
    else if (tx_busy)
      tx_sh <= {1'b1, tx_sh[msg_bits:1]};
  end

  // Stop bit sampled high with a full message in the shifter
  assign rx_done = rx_busy && rx_cnt == 7'(msg_bits) && bus_rx;

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      rx_busy  <= 1'b0;
      rx_prev  <= 1'b1;
      rx_cnt   <= '0;
      rx_valid <= 1'b0;
      overrun  <= 1'b0;
    end
    else
    begin
      rx_prev <= bus_rx;
      overrun <= 1'b0;
      if (rx_grant)
        rx_valid <= 1'b0;
      if (!rx_busy)
      begin
        if (rx_prev && !bus_rx)
        begin
          rx_busy <= 1'b1;
          rx_cnt  <= '0;
        end
      end
      else
      begin
        rx_cnt <= rx_cnt + 1'b1;
        if (rx_cnt == 7'(msg_bits))
          rx_busy <= 1'b0;
      end
      if (rx_done)
      begin
        if (!rx_valid || rx_grant)
          rx_valid <= 1'b1;
        else
          overrun <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_40)
  begin
    if (rx_busy && rx_cnt != 7'(msg_bits))
      rx_sh <= {bus_rx, rx_sh[msg_bits-1:1]};
    if (rx_done && (!rx_valid || rx_grant))
      rx_msg <= can_msg_t'(rx_sh);
  end

endmodule

//--- uplink_arbiter.sv
`timescale 1ns/1ps

module uplink_arbiter
  import mopshub_pkg::*;
(
  input  logic                      clk_40,
  input  logic                      rst,
  input  logic [n_buses-1:0]        rx_valid,
  output logic [n_buses-1:0]        rx_grant,
  input  can_msg_t [n_buses-1:0]    rx_msgs,
  input  logic                      fifo_full,
  output logic                      push,
  output hub_frame_t                push_frame
);

  logic [$clog2(n_buses)-1:0] rr_ptr;
  logic [$clog2(n_buses)-1:0] sel;
  logic                       found;

  // First requester at or after the pointer
  always_comb
  begin : pick
    int cand;
    found = 1'b0;
    sel   = rr_ptr;
    for (int i = 0; i < n_buses; i++)
    begin
      cand = (int'(rr_ptr) + i) % n_buses;
      if (!found && rx_valid[cand])
      begin
        found = 1'b1;
        sel   = ($clog2(n_buses))'(cand);
      end
    end
  end

  // No grant while the uplink FIFO is full
  assign push     = found && !fifo_full;
  assign rx_grant = push ? (n_buses'(1) << sel) : '0;

  assign push_frame.bus_id = bus_id_w'(sel);
  assign push_frame.msg    = rx_msgs[sel];

  always_ff @(posedge clk_40)
  begin
    if (!rst)
      rr_ptr <= '0;
    else if (push)
      rr_ptr <= sel + 1'b1;
  end

endmodule

//--- hub_apb_regs.sv
`timescale 1ns/1ps

module hub_apb_regs
  import mopshub_pkg::*;
(
  input  logic               clk_40,
  input  logic               rst,
  input  apb_req_t           apb_req,
  output apb_rsp_t           apb_rsp,
  input  logic               tx_pulse,
  input  logic               up_pulse,
  input  logic               drop_pulse,
  output logic [n_buses-1:0] bus_en
);

  logic [2:0]       pulses;
  logic [2:0][31:0] counts;
  logic [31:0]      rd_data;
  logic             rd_err;
  logic [31:0]      prdata_q;
  logic             pslverr_q;
  logic             setup_phase;
  logic             access_phase;

  // Counter order is tx, rx, drop
  assign pulses       = {drop_pulse, up_pulse, tx_pulse};
  assign setup_phase  = apb_req.psel && !apb_req.penable;
  assign access_phase = apb_req.psel && apb_req.penable;

  always_comb
  begin
    rd_err  = 1'b0;
    rd_data = '0;
    case (apb_req.paddr)
      addr_bus_en:     rd_data = 32'(bus_en);
      addr_tx_count:   rd_data = counts[0];
      addr_rx_count:   rd_data = counts[1];
      addr_drop_count: rd_data = counts[2];
      default:         rd_err  = 1'b1;
    endcase
  end

  // Response captured in setup, shown during access
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      prdata_q  <= '0;
      pslverr_q <= 1'b0;
    end
    else if (setup_phase)
    begin
      prdata_q  <= rd_data;
      pslverr_q <= rd_err;
    end
    else
      pslverr_q <= 1'b0;
  end

  always_ff @(posedge clk_40)
  begin
    if (!rst)
      bus_en <= bus_en_reset;
    else if (access_phase && apb_req.pwrite && apb_req.paddr == addr_bus_en)
      bus_en <= apb_req.pwdata[n_buses-1:0];
  end

  // Counters stick at all ones
  always_ff @(posedge clk_40)
  begin
    if (!rst)
      counts <= '0;
    else
    begin
      for (int i = 0; i < 3; i++)
      begin
        if (pulses[i] && counts[i] != '1)
          counts[i] <= counts[i] + 1'b1;
      end
    end
  end

  assign apb_rsp.prdata  = prdata_q;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = pslverr_q;

endmodule

//--- mopshub_top.sv
`timescale 1ns/1ps

module mopshub_top
  import mopshub_pkg::*;
(
  input  logic               clk_40,
  input  logic               rst,
  input  logic [1:0]         elink_rx,
  output logic [1:0]         elink_tx,
  output logic [n_buses-1:0] bus_tx,
  input  logic [n_buses-1:0] bus_rx,
  input  apb_req_t           apb_req,
  output apb_rsp_t           apb_rsp
);

  logic                       dn_valid;
  hub_frame_t                 dn_frame;
  logic [$clog2(n_buses)-1:0] sel_id;
  logic                       id_ok;
  logic                       route_ok;
  logic [n_buses-1:0]         bus_en;
  logic [n_buses-1:0]         tx_push;
  logic [n_buses-1:0]         tx_full;
  logic [n_buses-1:0]         rx_valid;
  logic [n_buses-1:0]         rx_grant;
  logic [n_buses-1:0]         overrun;
  can_msg_t [n_buses-1:0]     rx_msgs;
  logic                       up_push;
  hub_frame_t                 up_push_frame;
  logic                       up_full;
  logic                       up_empty;
  logic                       up_ready;
  logic                       up_pop;
  hub_frame_t                 up_frame;
  logic                       tx_pulse;
  logic                       up_pulse;
  logic                       drop_pulse;

  elink_deser i_elink_deser (
    .clk_40   (clk_40),
    .rst      (rst),
    .elink_rx (elink_rx),
    .dn_valid (dn_valid),
    .dn_frame (dn_frame)
  );

  // Downlink routing: known bus, enabled, room in its queue
  assign id_ok    = dn_frame.bus_id < bus_id_w'(n_buses);
  assign sel_id   = dn_frame.bus_id[$clog2(n_buses)-1:0];
  assign route_ok = id_ok && bus_en[sel_id] && !tx_full[sel_id];
  assign tx_pulse = dn_valid && route_ok;
  assign tx_push  = tx_pulse ? (n_buses'(1) << sel_id) : '0;

  // Rejected frames and lost rx messages share one counter
  assign drop_pulse = (dn_valid && !route_ok) || |overrun;

  for (genvar i = 0; i < n_buses; i++)
  begin : g_chan
    bus_channel i_bus_channel (
      .clk_40   (clk_40),
      .rst      (rst),
      .tx_push  (tx_push[i]),
      .tx_msg   (dn_frame.msg),
      .tx_full  (tx_full[i]),
      .bus_tx   (bus_tx[i]),
      .bus_rx   (bus_rx[i]),
      .rx_valid (rx_valid[i]),
      .rx_msg   (rx_msgs[i]),
      .rx_grant (rx_grant[i]),
      .overrun  (overrun[i])
    );
  end

  uplink_arbiter i_uplink_arbiter (
    .clk_40     (clk_40),
    .rst        (rst),
    .rx_valid   (rx_valid),
    .rx_grant   (rx_grant),
    .rx_msgs    (rx_msgs),
    .fifo_full  (up_full),
    .push       (up_push),
    .push_frame (up_push_frame)
  );

  sync_fifo #(
    .item_t (hub_frame_t),
    .depth  (up_fifo_depth)
  ) i_up_fifo (
    .clk_40    (clk_40),
    .rst       (rst),
    .push      (up_push),
    .push_item (up_push_frame),
    .full      (up_full),
    .pop       (up_pop),
    .pop_item  (up_frame),
    .empty     (up_empty)
  );

  assign up_pop = !up_empty && up_ready;

  elink_ser i_elink_ser (
    .clk_40   (clk_40),
    .rst      (rst),
    .up_valid (!up_empty),
    .up_frame (up_frame),
    .up_ready (up_ready),
    .elink_tx (elink_tx),
    .up_pulse (up_pulse)
  );

  hub_apb_regs i_hub_apb_regs (
    .clk_40     (clk_40),
    .rst        (rst),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .tx_pulse   (tx_pulse),
    .up_pulse   (up_pulse),
    .drop_pulse (drop_pulse),
    .bus_en     (bus_en)
  );

endmodule

//--- mopshub_props.sv
`timescale 1ns/1ps

module mopshub_props
  import mopshub_pkg::*;
(
  input logic               clk_40,
  input logic               rst,
  input logic [1:0]         elink_tx,
  input logic [n_buses-1:0] bus_tx,
  input logic [n_buses-1:0] tx_push,
  input logic [n_buses-1:0] tx_full,
  input logic               up_push,
  input logic               up_full,
  input apb_req_t           apb_req,
  input apb_rsp_t           apb_rsp
);

  bit   bus_idle_bad  = 1'b0;
  bit   elink_rst_bad = 1'b0;
  bit   slverr_bad    = 1'b0;
  bit   chan_ovf_bad  = 1'b0;
  bit   up_ovf_bad    = 1'b0;
  logic pushed;
  logic any_fail;

  assign any_fail = bus_idle_bad | elink_rst_bad | slverr_bad | chan_ovf_bad | up_ovf_bad;

  // Set once any channel queue took a message
  always_ff @(posedge clk_40)
  begin
    if (!rst)
      pushed <= 1'b0;
    else if (|tx_push)
      pushed <= 1'b1;
  end

  bus_idle_until_push: assert property (
    @(posedge clk_40) disable iff (!rst) !pushed |-> bus_tx == '1
  )
  else
  begin
    bus_idle_bad = 1'b1;
    $error("bus_tx left idle before any channel push");
  end

  elink_idle_in_reset: assert property (
    @(posedge clk_40) !rst && $past(!rst) |-> elink_tx == elink_idle
  )
  else
  begin
    elink_rst_bad = 1'b1;
    $error("elink_tx not idle during reset");
  end

  slverr_in_access: assert property (
    @(posedge clk_40) disable iff (!rst)
      apb_rsp.pslverr |-> apb_req.psel && apb_req.penable
  )
  else
  begin
    slverr_bad = 1'b1;
    $error("pslverr outside an APB access phase");
  end

  chan_no_overflow: assert property (
    @(posedge clk_40) disable iff (!rst) (tx_push & tx_full) == '0
  )
  else
  begin
    chan_ovf_bad = 1'b1;
    $error("channel FIFO pushed while full");
  end

  up_no_overflow: assert property (
    @(posedge clk_40) disable iff (!rst) !(up_push && up_full)
  )
  else
  begin
    up_ovf_bad = 1'b1;
    $error("uplink FIFO pushed while full");
  end

endmodule

bind mopshub_top mopshub_props i_mopshub_props (.*);

//--- tb_mopshub_top.sv
`timescale 1ns/1ps

module tb_mopshub_top
  import mopshub_pkg::*;
();

  logic               clk_40;
  logic               rst;
  logic [1:0]         elink_rx;
  logic [1:0]         elink_tx;
  logic [n_buses-1:0] bus_tx;
  logic [n_buses-1:0] bus_rx;
  apb_req_t           apb_req;
  apb_rsp_t           apb_rsp;
  int                 seed = 56470;

  mopshub_top i_mopshub_top (
    .clk_40   (clk_40),
    .rst      (rst),
    .elink_rx (elink_rx),
    .elink_tx (elink_tx),
    .bus_tx   (bus_tx),
    .bus_rx   (bus_rx),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp)
  );

  // Every field bus talks to itself
  assign bus_rx = bus_tx;

  initial
  begin
    clk_40 = 1'b0;
    forever #5 clk_40 = ~clk_40;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [frame_w-1:0] expected,
                             input logic [frame_w-1:0] actual);
    assert (actual === expected)
    else
    begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // Setup on one falling edge, access on the next
  task automatic apb_access(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    waited = 0;
    @(negedge clk_40);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk_40);
    apb_req.penable = 1'b1;
    while (!apb_rsp.pready)
    begin
      waited++;
      if (waited > 16)
        abort_run("APB slave never raised pready");
      @(negedge clk_40);
    end
    // Response holds until the access edge
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk_40);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused_data;
    logic        unused_err;
    apb_access(1'b1, addr, data, unused_data, unused_err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  task automatic read_check(input string name, input logic [3:0] addr,
                            input logic [31:0] expected);
    logic [31:0] rdata;
    logic        err;
    apb_read(addr, rdata, err);
    check_value({name, " pslverr"}, 1'b0, frame_w'(err));
    check_value(name, frame_w'(expected), frame_w'(rdata));
  endtask

  task automatic send_frame(input hub_frame_t frame);
    logic [frame_w-1:0] bits;
    bits = frame;
    @(negedge clk_40);
    elink_rx = elink_start;
    for (int i = 0; i < sym_per_frame; i++)
    begin
      @(negedge clk_40);
      elink_rx = bits[frame_w-1-2*i -: 2];
    end
    @(negedge clk_40);
    elink_rx = elink_idle;
  endtask

  task automatic get_frame(input int limit, output hub_frame_t frame);
    logic [frame_w-1:0] bits;
    int                 waited;
    waited = 0;
    @(negedge clk_40);
    while (elink_tx != elink_start)
    begin
      waited++;
      if (waited > limit)
        abort_run("No frame started on elink_tx before the timeout");
      @(negedge clk_40);
    end
    for (int i = 0; i < sym_per_frame; i++)
    begin
      @(negedge clk_40);
      bits = {bits[frame_w-3:0], elink_tx};
    end
    frame = hub_frame_t'(bits);
  endtask

  // Nothing may start on the uplink for a while
  task automatic expect_silence(input string name, input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge clk_40);
      check_value(name, elink_idle, frame_w'(elink_tx));
    end
  endtask

  function automatic can_msg_t random_msg();
    can_msg_t msg;
    msg.cob_id = 12'($random(seed));
    msg.data   = {24'($random(seed)), 32'($random(seed))};
    return msg;
  endfunction

  initial
  begin
    repeat (20000) @(posedge clk_40);
    abort_run("Simulation did not finish within the cycle limit");
  end

  initial
  begin : main
    hub_frame_t         sent;
    hub_frame_t         got;
    hub_frame_t         pair [2];
    hub_frame_t         burst [n_buses];
    hub_frame_t         returned [$];
    logic [n_buses-1:0] seen;
    logic [31:0]        rdata;
    logic               err;
    logic [31:0]        tx_base;
    logic [31:0]        rx_base;
    logic [31:0]        drop_base;
    logic [3:0]         cnt_addr [3];

    rst      = 1'b0;
    elink_rx = elink_idle;
    apb_req  = '0;
    cnt_addr = '{addr_tx_count, addr_rx_count, addr_drop_count};
    repeat (10) @(posedge clk_40);
    @(negedge clk_40);
    rst = 1'b1;

    // Reset state
    check_value("reset elink_tx", elink_idle, frame_w'(elink_tx));
    check_value("reset bus_tx", frame_w'({n_buses{1'b1}}), frame_w'(bus_tx));
    read_check("reset bus_en", addr_bus_en, 32'h0000_00FF);
    read_check("reset tx_count", addr_tx_count, 32'd0);
    read_check("reset rx_count", addr_rx_count, 32'd0);
    read_check("reset drop_count", addr_drop_count, 32'd0);

    // Single frames through a few buses
    for (int k = 0; k < n_buses; k += 3)
    begin
      sent.bus_id = bus_id_w'(k);
      sent.msg    = random_msg();
      send_frame(sent);
      get_frame(600, got);
      check_value("loopback", sent, got);
    end

    // Two frames on one bus keep their order
    pair[0].bus_id = 8'd5;
    pair[0].msg    = random_msg();
    pair[1].bus_id = 8'd5;
    pair[1].msg    = random_msg();
    fork
      begin
        send_frame(pair[0]);
        send_frame(pair[1]);
      end
      begin
        get_frame(800, got);
        check_value("in order first", pair[0], got);
        get_frame(800, got);
        check_value("in order second", pair[1], got);
      end
    join

    // Unknown bus and disabled bus
    apb_read(addr_tx_count, tx_base, err);
    apb_read(addr_drop_count, drop_base, err);
    sent.bus_id = 8'd9;
    sent.msg    = random_msg();
    send_frame(sent);
    expect_silence("drop unknown bus", 300);
    apb_write(addr_bus_en, 32'h0000_00F7);
    sent.bus_id = 8'd3;
    send_frame(sent);
    expect_silence("drop disabled bus", 300);
    read_check("drop_count after drops", addr_drop_count, drop_base + 32'd2);
    read_check("tx_count after drops", addr_tx_count, tx_base);
    apb_write(addr_bus_en, 32'(bus_en_reset));

    // One frame per bus, back to back
    apb_read(addr_tx_count, tx_base, err);
    apb_read(addr_rx_count, rx_base, err);
    for (int k = 0; k < n_buses; k++)
    begin
      burst[k].bus_id = bus_id_w'(k);
      burst[k].msg    = random_msg();
    end
    returned.delete();
    fork
      for (int k = 0; k < n_buses; k++)
        send_frame(burst[k]);
      for (int k = 0; k < n_buses; k++)
      begin
        get_frame(1000, got);
        returned.push_back(got);
      end
    join
    seen = '0;
    foreach (returned[i])
    begin
      got = returned[i];
      check_value("burst bus_id range", 1'b1, frame_w'(got.bus_id < bus_id_w'(n_buses)));
      check_value("burst duplicate bus", 1'b0, frame_w'(seen[got.bus_id[2:0]]));
      seen[got.bus_id[2:0]] = 1'b1;
      check_value("burst payload", burst[got.bus_id[2:0]], got);
    end
    check_value("burst all buses", frame_w'({n_buses{1'b1}}), frame_w'(seen));
    read_check("burst tx_count", addr_tx_count, tx_base + 32'd8);
    read_check("burst rx_count", addr_rx_count, rx_base + 32'd8);

    // Register access rules
    apb_write(addr_bus_en, 32'h0000_005A);
    read_check("bus_en readback", addr_bus_en, 32'h0000_005A);
    apb_write(addr_bus_en, 32'(bus_en_reset));
    apb_read(4'h2, rdata, err);
    check_value("unmapped pslverr", 1'b1, frame_w'(err));
    check_value("unmapped prdata", 32'd0, frame_w'(rdata));
    foreach (cnt_addr[i])
    begin
      apb_read(cnt_addr[i], rdata, err);
      apb_write(cnt_addr[i], 32'hDEAD_BEEF);
      read_check("counter write ignored", cnt_addr[i], rdata);
    end

    if (i_mopshub_top.i_mopshub_props.any_fail)
    begin
      $display("A bound property of the DUT failed");
      $display("*** FAILED ***");
      $fatal(1, "property failure");
    end
    else
    begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- tb.f
mopshub_pkg.sv
sync_fifo.sv
elink_deser.sv
elink_ser.sv
bus_channel.sv
uplink_arbiter.sv
hub_apb_regs.sv
mopshub_top.sv
mopshub_props.sv
tb_mopshub_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mopshub_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
